/* hdl/reg_pkg.sv */
// register manager shared definitions
package reg_pkg;

    // bus and register widths
    localparam int REG_W      = 64;
    localparam int REG_ADDR_W = 16;
    localparam int DDR_ADDR_W = 32;

    // register window, in window when bits outside the mask equal the base
    localparam logic [REG_ADDR_W-1:0] ADDR_BASE = 16'h0000;
    localparam logic [REG_ADDR_W-1:0] ADDR_MASK = 16'h00ff;

    // register offsets
    localparam logic [REG_ADDR_W-1:0] TX_CFG_REG    = 16'h0008;
    localparam logic [REG_ADDR_W-1:0] RX_CFG_REG    = 16'h0010;
    localparam logic [REG_ADDR_W-1:0] TX_ADDR_REG   = 16'h0020;
    localparam logic [REG_ADDR_W-1:0] TX_LENGTH_REG = 16'h0028;
    localparam logic [REG_ADDR_W-1:0] TX_PACKET_REG = 16'h0030;
    localparam logic [REG_ADDR_W-1:0] TX_STATUS_REG = 16'h0038;
    localparam logic [REG_ADDR_W-1:0] RX_ADDR_REG   = 16'h0040;
    localparam logic [REG_ADDR_W-1:0] RX_CTRL_REG   = 16'h0048;
    localparam logic [REG_ADDR_W-1:0] RX_STATUS_REG = 16'h0050;
    localparam logic [REG_ADDR_W-1:0] RX_CTRL_REG2  = 16'h0058;
    localparam logic [REG_ADDR_W-1:0] IRQ_REG       = 16'h0060;
    localparam logic [REG_ADDR_W-1:0] SOFT_R_REG    = 16'h0070;

    // tx packet word fields
    localparam int TXP_BODY_LSB = 0;
    localparam int TXP_BODY_W   = 16;
    localparam int TXP_NUM_LSB  = 16;
    localparam int TXP_NUM_W    = 24;
    localparam int TXP_TAIL_LSB = 40;
    localparam int TXP_TAIL_W   = 16;
    localparam int TXP_PRE_BIT  = 59;
    localparam int TXP_MODE_LSB = 60;
    localparam int TXP_MODE_W   = 3;
    localparam int TXP_LOOP_BIT = 63;

    // rx control word fields
    localparam int RXC_FIFO_BIT  = 0;
    localparam int RXC_LINK_BIT  = 1;
    localparam int RXC_SYNC_BIT  = 2;
    localparam int RXC_START_BIT = 3;
    localparam int RXC_TIMES_LSB = 4;
    localparam int RXC_GAP_LSB   = 12;
    localparam int RXC_WIDTH_LSB = 40;

    // widths shared between blocks
    localparam int TX_LEN_W     = 32;
    localparam int LINE_NUM_W   = 24;
    localparam int TX_STATUS_W  = 10;
    localparam int RX_STATUS_W  = 6;
    localparam int RX_FLEN_W    = 16;
    localparam int TX_CNT_W     = 16;
    localparam int RX_CNT_W     = 12;
    localparam int AUTO_TIMES_W = 8;
    localparam int AUTO_GAP_W   = 28;
    localparam int AUTO_WIDTH_W = 8;

    // status word codes, tags and marks
    localparam logic [3:0]  IRQ_CODE_TX   = 4'd1;
    localparam logic [3:0]  IRQ_CODE_RX   = 4'd2;
    localparam logic [3:0]  IRQ_CODE_LOSS = 4'd3;
    localparam logic [3:0]  IRQ_CODE_AUTO = 4'd4;
    localparam logic [3:0]  TX_STATUS_TAG = 4'h9;
    localparam logic [3:0]  RX_STATUS_TAG = 4'ha;
    localparam logic [15:0] TX_IRQ_MARK   = 16'h5aa5;
    localparam logic [15:0] AUTO_IRQ_MARK = 16'hffff;

    // soft reset pulse
    localparam int SOFT_RST_CYCLES = 256;
    localparam int SOFT_CNT_W      = $clog2(SOFT_RST_CYCLES);

endpackage

/* hdl/reg_bus_stage.sv */
// register bus input pipeline
`timescale 1ns/10ps

module reg_bus_stage
    import reg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_reg_wen,
    input  logic [REG_ADDR_W-1:0] i_reg_waddr,
    input  logic [REG_W-1:0]      i_reg_wdata,
    input  logic                  i_reg_ren,
    input  logic [REG_ADDR_W-1:0] i_reg_raddr,
    output logic                  o_wr_stb,
    output logic [REG_ADDR_W-1:0] o_wr_addr,
    output logic [REG_W-1:0]      o_wr_data,
    output logic                  o_rd_stb,
    output logic [REG_ADDR_W-1:0] o_rd_addr
);

    logic [1:0]                  wen_q, wsel_q, ren_q, rsel_q;
    logic [1:0][REG_ADDR_W-1:0]  waddr_q, raddr_q;
    logic [1:0][REG_W-1:0]       wdata_q;

    // control stages, window hit travels with the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            wen_q    <= '0;
            ren_q    <= '0;
            wsel_q   <= '0;
            rsel_q   <= '0;
            o_wr_stb <= 1'b0;
            o_rd_stb <= 1'b0;
        end else begin
            wen_q    <= {wen_q[0], i_reg_wen};
            ren_q    <= {ren_q[0], i_reg_ren};
            wsel_q   <= {wsel_q[0], (i_reg_waddr & ~ADDR_MASK) == ADDR_BASE};
            rsel_q   <= {rsel_q[0], (i_reg_raddr & ~ADDR_MASK) == ADDR_BASE};
            o_wr_stb <= wen_q[1] & wsel_q[1];
            o_rd_stb <= ren_q[1] & rsel_q[1];
        end
    end

    // address and data stages
    always_ff @(posedge clk) begin
        waddr_q   <= {waddr_q[0], i_reg_waddr};
        raddr_q   <= {raddr_q[0], i_reg_raddr};
        wdata_q   <= {wdata_q[0], i_reg_wdata};
        o_wr_addr <= waddr_q[1];
        o_rd_addr <= raddr_q[1];
        o_wr_data <= wdata_q[1];
    end

endmodule

/* hdl/cfg_regs.sv */
// configuration register file
`timescale 1ns/10ps

module cfg_regs
    import reg_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_wr_stb,
    input  logic [REG_ADDR_W-1:0]   i_wr_addr,
    input  logic [REG_W-1:0]        i_wr_data,
    input  logic                    i_rd_stb,
    input  logic [REG_ADDR_W-1:0]   i_rd_addr,
    input  logic [TX_STATUS_W-1:0]  i_tx_status,
    input  logic [RX_STATUS_W-1:0]  i_rx_status,
    input  logic [REG_W-1:0]        i_irq_status,
    output logic [DDR_ADDR_W-1:0]   o_tx_base_addr,
    output logic [TX_LEN_W-1:0]     o_tx_total_length,
    output logic [TXP_BODY_W-1:0]   o_tx_packet_body,
    output logic [TXP_NUM_W-1:0]    o_tx_body_num,
    output logic [TXP_TAIL_W-1:0]   o_tx_packet_tail,
    output logic                    o_tx_pre,
    output logic [TXP_MODE_W-1:0]   o_tx_mode,
    output logic                    o_loopback_ena,
    output logic [DDR_ADDR_W-1:0]   o_rx_base_addr,
    output logic                    o_rx_fifo_rd,
    output logic                    o_link_loss_detect_ena,
    output logic                    o_sync_loss_detect_ena,
    output logic [LINE_NUM_W-1:0]   o_line_num_per_intr,
    output logic                    o_auto_start,
    output logic [AUTO_TIMES_W-1:0] o_auto_times,
    output logic [AUTO_GAP_W-1:0]   o_auto_gap,
    output logic [AUTO_WIDTH_W-1:0] o_auto_width,
    output logic                    o_tx_config_done,
    output logic                    o_rx_config_done,
    output logic                    o_soft_rst,
    output logic [REG_W-1:0]        o_reg_rdata
);

    logic [REG_W-1:0]      tx_addr_reg, tx_length_reg, tx_packet_reg;
    logic [REG_W-1:0]      rx_addr_reg, rx_ctrl_reg, rx_ctrl_reg2;
    logic [REG_W-1:0]      rd_word;
    logic [REG_ADDR_W-1:0] wr_off, rd_off;
    logic [SOFT_CNT_W-1:0] soft_cnt;

    // offsets inside the window
    assign wr_off = i_wr_addr & ADDR_MASK;
    assign rd_off = i_rd_addr & ADDR_MASK;

    //////////////////////////////////////////////////////////////////////
    // write decode and config-done strobes
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_addr_reg   <= '0;
            tx_length_reg <= '0;
            tx_packet_reg <= '0;
            rx_addr_reg   <= '0;
            rx_ctrl_reg   <= '0;
            rx_ctrl_reg2  <= '0;
        end else if (i_wr_stb) begin
            case (wr_off)
                TX_ADDR_REG:   tx_addr_reg   <= i_wr_data;
                TX_LENGTH_REG: tx_length_reg <= i_wr_data;
                TX_PACKET_REG: tx_packet_reg <= i_wr_data;
                RX_ADDR_REG:   rx_addr_reg   <= i_wr_data;
                RX_CTRL_REG:   rx_ctrl_reg   <= i_wr_data;
                RX_CTRL_REG2:  rx_ctrl_reg2  <= i_wr_data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_tx_config_done <= 1'b0;
            o_rx_config_done <= 1'b0;
        end else begin
            o_tx_config_done <= i_wr_stb && (wr_off == TX_CFG_REG);
            o_rx_config_done <= i_wr_stb && (wr_off == RX_CFG_REG);
        end
    end

    // field slices
    assign o_tx_base_addr    = tx_addr_reg[DDR_ADDR_W-1:0];
    assign o_tx_total_length = tx_length_reg[TX_LEN_W-1:0];
    assign o_tx_packet_body  = tx_packet_reg[TXP_BODY_LSB +: TXP_BODY_W];
    assign o_tx_body_num     = tx_packet_reg[TXP_NUM_LSB +: TXP_NUM_W];
    assign o_tx_packet_tail  = tx_packet_reg[TXP_TAIL_LSB +: TXP_TAIL_W];
    assign o_tx_pre          = tx_packet_reg[TXP_PRE_BIT];
    assign o_tx_mode         = tx_packet_reg[TXP_MODE_LSB +: TXP_MODE_W];
    assign o_loopback_ena    = tx_packet_reg[TXP_LOOP_BIT];

    assign o_rx_base_addr         = rx_addr_reg[DDR_ADDR_W-1:0];
    assign o_rx_fifo_rd           = rx_ctrl_reg[RXC_FIFO_BIT];
    assign o_link_loss_detect_ena = rx_ctrl_reg[RXC_LINK_BIT];
    assign o_sync_loss_detect_ena = rx_ctrl_reg[RXC_SYNC_BIT];
    assign o_auto_start           = rx_ctrl_reg[RXC_START_BIT];
    assign o_auto_times           = rx_ctrl_reg[RXC_TIMES_LSB +: AUTO_TIMES_W];
    assign o_auto_gap             = rx_ctrl_reg[RXC_GAP_LSB +: AUTO_GAP_W];
    assign o_auto_width           = rx_ctrl_reg[RXC_WIDTH_LSB +: AUTO_WIDTH_W];
    assign o_line_num_per_intr    = rx_ctrl_reg2[LINE_NUM_W-1:0];

    //////////////////////////////////////////////////////////////////////
    // soft reset pulse
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            o_soft_rst <= 1'b0;
            soft_cnt   <= '0;
        end else if (i_wr_stb && (wr_off == SOFT_R_REG)) begin
            o_soft_rst <= 1'b1;
            soft_cnt   <= SOFT_CNT_W'(SOFT_RST_CYCLES - 1);
        end else if (o_soft_rst) begin
            // drop after the last counted cycle
            if (soft_cnt == '0)
                o_soft_rst <= 1'b0;
            else
                soft_cnt <= soft_cnt - 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read-back
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (rd_off)
            TX_ADDR_REG:   rd_word = tx_addr_reg;
            TX_LENGTH_REG: rd_word = tx_length_reg;
            TX_PACKET_REG: rd_word = tx_packet_reg;
            RX_ADDR_REG:   rd_word = rx_addr_reg;
            RX_CTRL_REG:   rd_word = rx_ctrl_reg;
            TX_STATUS_REG: rd_word = {TX_STATUS_TAG, {(REG_W-4-TX_STATUS_W){1'b0}}, i_tx_status};
            RX_STATUS_REG: rd_word = {RX_STATUS_TAG, {(REG_W-4-RX_STATUS_W){1'b0}}, i_rx_status};
            IRQ_REG:       rd_word = i_irq_status;
            default:       rd_word = '0;
        endcase
    end

    // data only in the cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst)
            o_reg_rdata <= '0;
        else
            o_reg_rdata <= i_rd_stb ? rd_word : '0;
    end

    // config writes are spaced, the done strobes never run back to back
    a_done_single: assert property (@(posedge clk) disable iff (rst)
        (o_tx_config_done || o_rx_config_done) |=> !(o_tx_config_done || o_rx_config_done));

endmodule

/* hdl/auto_intr_gen.sv */
// automatic interrupt pulse train
`timescale 1ns/10ps

module auto_intr_gen
    import reg_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_start,
    input  logic [AUTO_TIMES_W-1:0] i_times,
    input  logic [AUTO_GAP_W-1:0]   i_gap,
    input  logic [AUTO_WIDTH_W-1:0] i_width,
    output logic                    o_pulse,
    output logic [AUTO_TIMES_W-1:0] o_count
);

    logic                  start_d;
    logic                  gen_en;
    // gap plus width needs one extra bit
    logic [AUTO_GAP_W:0]   cyc_cnt;
    logic                  start_rise;
    logic                  pulse_end;

    assign start_rise = i_start & ~start_d;
    assign pulse_end  = o_pulse && (cyc_cnt == ({1'b0, i_gap} + i_width));

    always_ff @(posedge clk) begin
        if (rst)
            start_d <= 1'b0;
        else
            start_d <= i_start;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gen_en  <= 1'b0;
            cyc_cnt <= '0;
            o_pulse <= 1'b0;
            o_count <= '0;
        end else if (start_rise) begin
            gen_en  <= 1'b1;
            cyc_cnt <= '0;
            o_pulse <= 1'b0;
            o_count <= '0;
        end else if (gen_en) begin
            cyc_cnt <= cyc_cnt + 1'b1;
            if (pulse_end) begin
                // fall of the pulse, restart the gap
                o_pulse <= 1'b0;
                cyc_cnt <= '0;
                o_count <= o_count + 1'b1;
                if (o_count + 1'b1 == i_times)
                    gen_en <= 1'b0;
            end else if (!o_pulse && cyc_cnt == {1'b0, i_gap}) begin
                o_pulse <= 1'b1;
            end
        end else begin
            cyc_cnt <= '0;
            o_pulse <= 1'b0;
        end
    end

    a_no_idle_pulse: assert property (@(posedge clk) disable iff (rst)
        !gen_en |-> !o_pulse);

endmodule

/* hdl/intr_report.sv */
// interrupt counters and status word
`timescale 1ns/10ps

module intr_report
    import reg_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_tx_interrupt,
    input  logic                    i_rx_interrupt,
    input  logic                    i_loss_interrupt,
    input  logic                    i_sync_loss,
    input  logic                    i_link_loss,
    input  logic [RX_STATUS_W-1:0]  i_rx_status,
    input  logic [RX_FLEN_W-1:0]    i_rx_frame_length,
    input  logic                    i_auto_pulse,
    input  logic [AUTO_TIMES_W-1:0] i_auto_count,
    input  logic                    i_soft_rst,
    output logic [REG_W-1:0]        o_irq_status
);

    logic                tx_d, rx_d, loss_d, auto_d;
    logic [TX_CNT_W-1:0] tx_cnt;
    logic [RX_CNT_W-1:0] rx_cnt;

    // delayed levels for edge detect and status latch
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_d   <= 1'b0;
            rx_d   <= 1'b0;
            loss_d <= 1'b0;
            auto_d <= 1'b0;
        end else begin
            tx_d   <= i_tx_interrupt;
            rx_d   <= i_rx_interrupt;
            loss_d <= i_loss_interrupt;
            auto_d <= i_auto_pulse;
        end
    end

    // rising edge counters also cleared by soft reset
    always_ff @(posedge clk) begin
        if (rst || i_soft_rst) begin
            tx_cnt <= '0;
            rx_cnt <= '0;
        end else begin
            if (i_tx_interrupt && !tx_d)
                tx_cnt <= tx_cnt + 1'b1;
            if (i_rx_interrupt && !rx_d)
                rx_cnt <= rx_cnt + 1'b1;
        end
    end

    // status word by priority rx, tx, loss, auto
    always_ff @(posedge clk) begin
        if (rst)
            o_irq_status <= '0;
        else if (rx_d)
            o_irq_status <= {IRQ_CODE_RX, rx_cnt, i_rx_frame_length,
                             {(REG_W-4-RX_CNT_W-RX_FLEN_W){1'b0}}};
        else if (tx_d)
            o_irq_status <= {IRQ_CODE_TX, {(REG_W-4-TX_CNT_W-16){1'b0}}, tx_cnt, TX_IRQ_MARK};
        else if (loss_d)
            o_irq_status <= {IRQ_CODE_LOSS, {(REG_W-4-RX_STATUS_W-2){1'b0}},
                             i_rx_status, i_sync_loss, i_link_loss};
        else if (auto_d)
            o_irq_status <= {IRQ_CODE_AUTO, {(REG_W-4-AUTO_TIMES_W-16){1'b0}},
                             i_auto_count, AUTO_IRQ_MARK};
    end

endmodule

/* hdl/reg_mgt_top.sv */
// transceiver register manager top
`timescale 1ns/10ps

module reg_mgt_top
    import reg_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_reg_wen,
    input  logic [REG_ADDR_W-1:0]  i_reg_waddr,
    input  logic [REG_W-1:0]       i_reg_wdata,
    input  logic                   i_reg_ren,
    input  logic [REG_ADDR_W-1:0]  i_reg_raddr,
    output logic [REG_W-1:0]       o_reg_rdata,
    input  logic                   i_tx_interrupt,
    input  logic                   i_rx_interrupt,
    input  logic                   i_loss_interrupt,
    input  logic                   i_sync_loss,
    input  logic                   i_link_loss,
    input  logic [RX_STATUS_W-1:0] i_rx_status,
    input  logic [TX_STATUS_W-1:0] i_tx_status,
    input  logic [RX_FLEN_W-1:0]   i_rx_frame_length,
    output logic [DDR_ADDR_W-1:0]  o_tx_base_addr,
    output logic [TX_LEN_W-1:0]    o_tx_total_length,
    output logic [TXP_BODY_W-1:0]  o_tx_packet_body,
    output logic [TXP_NUM_W-1:0]   o_tx_body_num,
    output logic [TXP_TAIL_W-1:0]  o_tx_packet_tail,
    output logic                   o_tx_pre,
    output logic [TXP_MODE_W-1:0]  o_tx_mode,
    output logic                   o_loopback_ena,
    output logic [DDR_ADDR_W-1:0]  o_rx_base_addr,
    output logic                   o_rx_fifo_rd,
    output logic                   o_link_loss_detect_ena,
    output logic                   o_sync_loss_detect_ena,
    output logic [LINE_NUM_W-1:0]  o_line_num_per_intr,
    output logic                   o_tx_config_done,
    output logic                   o_rx_config_done,
    output logic                   o_soft_rst,
    output logic                   o_tx_irq,
    output logic                   o_rx_irq,
    output logic                   o_loss_irq
);

    logic                    wr_stb, rd_stb;
    logic [REG_ADDR_W-1:0]   wr_addr, rd_addr;
    logic [REG_W-1:0]        wr_data, irq_status;
    logic                    auto_start, auto_pulse;
    logic [AUTO_TIMES_W-1:0] auto_times, auto_count;
    logic [AUTO_GAP_W-1:0]   auto_gap;
    logic [AUTO_WIDTH_W-1:0] auto_width;

    reg_bus_stage u_bus (
        .clk(clk), .rst(rst),
        .i_reg_wen(i_reg_wen), .i_reg_waddr(i_reg_waddr), .i_reg_wdata(i_reg_wdata),
        .i_reg_ren(i_reg_ren), .i_reg_raddr(i_reg_raddr),
        .o_wr_stb(wr_stb), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
        .o_rd_stb(rd_stb), .o_rd_addr(rd_addr)
    );

    cfg_regs u_cfg (
        .clk(clk), .rst(rst),
        .i_wr_stb(wr_stb), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
        .i_rd_stb(rd_stb), .i_rd_addr(rd_addr),
        .i_tx_status(i_tx_status), .i_rx_status(i_rx_status), .i_irq_status(irq_status),
        .o_tx_base_addr(o_tx_base_addr), .o_tx_total_length(o_tx_total_length),
        .o_tx_packet_body(o_tx_packet_body), .o_tx_body_num(o_tx_body_num),
        .o_tx_packet_tail(o_tx_packet_tail), .o_tx_pre(o_tx_pre), .o_tx_mode(o_tx_mode),
        .o_loopback_ena(o_loopback_ena), .o_rx_base_addr(o_rx_base_addr),
        .o_rx_fifo_rd(o_rx_fifo_rd), .o_link_loss_detect_ena(o_link_loss_detect_ena),
        .o_sync_loss_detect_ena(o_sync_loss_detect_ena),
        .o_line_num_per_intr(o_line_num_per_intr),
        .o_auto_start(auto_start), .o_auto_times(auto_times),
        .o_auto_gap(auto_gap), .o_auto_width(auto_width),
        .o_tx_config_done(o_tx_config_done), .o_rx_config_done(o_rx_config_done),
        .o_soft_rst(o_soft_rst), .o_reg_rdata(o_reg_rdata)
    );

    auto_intr_gen u_auto (
        .clk(clk), .rst(rst),
        .i_start(auto_start), .i_times(auto_times), .i_gap(auto_gap), .i_width(auto_width),
        .o_pulse(auto_pulse), .o_count(auto_count)
    );

    intr_report u_irq (
        .clk(clk), .rst(rst),
        .i_tx_interrupt(i_tx_interrupt), .i_rx_interrupt(i_rx_interrupt),
        .i_loss_interrupt(i_loss_interrupt), .i_sync_loss(i_sync_loss),
        .i_link_loss(i_link_loss), .i_rx_status(i_rx_status),
        .i_rx_frame_length(i_rx_frame_length),
        .i_auto_pulse(auto_pulse), .i_auto_count(auto_count),
        .i_soft_rst(o_soft_rst), .o_irq_status(irq_status)
    );

    // interrupt lines, auto pulses share the rx line
    assign o_tx_irq   = i_tx_interrupt;
    assign o_rx_irq   = i_rx_interrupt | auto_pulse;
    assign o_loss_irq = i_loss_interrupt;

endmodule

/* tests/tb_reg_mgt_util.svh */
// register manager reference models
    // fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step for every bit taken
    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[62:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic bit in_window(input logic [REG_ADDR_W-1:0] a);
        return (a & ~ADDR_MASK) == ADDR_BASE;
    endfunction

    function automatic logic [31:0] slice_field(input logic [63:0] w, input int lsb,
                                                input int width);
        return 32'((w >> lsb) & ((64'd1 << width) - 64'd1));
    endfunction

    // code or tag on top, a value at pos, a mark in the low 16 bits
    function automatic logic [63:0] status_word(input logic [3:0] code, input logic [31:0] val,
                                                input int pos, input logic [15:0] low);
        return (64'(code) << 60) | (64'(val) << pos) | 64'(low);
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // compare tasks
    ///////////////////////////////////////////////////////////////////////
    task automatic check_word(input string name, input logic [REG_W-1:0] exp,
                              input logic [REG_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_field(input string name, input logic [DDR_ADDR_W-1:0] exp,
                               input logic [DDR_ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s expected %b actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

/* tests/tb_reg_mgt.sv */
// register manager testbench
`timescale 1ns/10ps

module tb_reg_mgt
    import reg_pkg::*;
();

    logic                   clk, rst, i_reg_wen, i_reg_ren;
    logic [REG_ADDR_W-1:0]  i_reg_waddr, i_reg_raddr;
    logic [REG_W-1:0]       i_reg_wdata, o_reg_rdata;
    logic                   i_tx_interrupt, i_rx_interrupt, i_loss_interrupt;
    logic                   i_sync_loss, i_link_loss;
    logic [RX_STATUS_W-1:0] i_rx_status;
    logic [TX_STATUS_W-1:0] i_tx_status;
    logic [RX_FLEN_W-1:0]   i_rx_frame_length;
    logic [DDR_ADDR_W-1:0]  o_tx_base_addr, o_rx_base_addr;
    logic [TX_LEN_W-1:0]    o_tx_total_length;
    logic [TXP_BODY_W-1:0]  o_tx_packet_body;
    logic [TXP_NUM_W-1:0]   o_tx_body_num;
    logic [TXP_TAIL_W-1:0]  o_tx_packet_tail;
    logic [TXP_MODE_W-1:0]  o_tx_mode;
    logic [LINE_NUM_W-1:0]  o_line_num_per_intr;
    logic                   o_tx_pre, o_loopback_ena, o_rx_fifo_rd;
    logic                   o_link_loss_detect_ena, o_sync_loss_detect_ena;
    logic                   o_tx_config_done, o_rx_config_done, o_soft_rst;
    logic                   o_tx_irq, o_rx_irq, o_loss_irq;

    logic [15:0]      lfsr_state = 16'd36992;
    int               cyc = 0;
    bit               checking = 1'b0;
    // expected read data and config-done strobes keyed by cycle
    logic [REG_W-1:0] rd_exp_q[$];
    string            rd_name_q[$];
    int               rd_due_q[$], tx_done_q[$], rx_done_q[$];

    reg_mgt_top UUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s", what);
        stop_with_failure();
    endtask

    `include "tb_reg_mgt_util.svh"

    // one-cycle strobe that returns on the falling edge after edge k+3
    task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [REG_W-1:0] data);
        if (in_window(addr) && (addr & ADDR_MASK) == TX_CFG_REG)
            tx_done_q.push_back(cyc + 4);
        if (in_window(addr) && (addr & ADDR_MASK) == RX_CFG_REG)
            rx_done_q.push_back(cyc + 4);
        i_reg_wen   = 1'b1;
        i_reg_waddr = addr;
        i_reg_wdata = data;
        @(negedge clk);
        i_reg_wen = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic read_expect(input logic [REG_ADDR_W-1:0] addr, input logic [REG_W-1:0] exp,
                               input string name);
        rd_due_q.push_back(cyc + 4);
        rd_exp_q.push_back(exp);
        rd_name_q.push_back(name);
        i_reg_ren   = 1'b1;
        i_reg_raddr = addr;
        @(negedge clk);
        i_reg_ren = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    // line 0 is tx, 1 is rx and 2 is loss
    // held for two edges then released
    task automatic pulse_interrupt(input int line);
        i_tx_interrupt   = (line == 0);
        i_rx_interrupt   = (line == 1);
        i_loss_interrupt = (line == 2);
        repeat (2) @(negedge clk);
        check_bit("tx irq line", i_tx_interrupt, o_tx_irq);
        check_bit("rx irq line", i_rx_interrupt, o_rx_irq);
        check_bit("loss irq line", i_loss_interrupt, o_loss_irq);
        {i_tx_interrupt, i_rx_interrupt, i_loss_interrupt} = '0;
        repeat (3) @(negedge clk);
    endtask

    ///////////////////////////////////////////////////////////////////////
    // response checker
    ///////////////////////////////////////////////////////////////////////
    // read data is zero outside its one cycle
    always @(negedge clk) begin
        logic [REG_W-1:0] exp_data;
        string            name;
        if (checking) begin
            exp_data = '0;
            name     = "idle read data";
            if (rd_due_q.size() > 0 && rd_due_q[0] == cyc) begin
                rd_due_q.delete(0);
                exp_data = rd_exp_q.pop_front();
                name     = rd_name_q.pop_front();
            end
            check_word(name, exp_data, o_reg_rdata);
            check_bit("tx config done", tx_done_q.size() > 0 && tx_done_q[0] == cyc,
                      o_tx_config_done);
            check_bit("rx config done", rx_done_q.size() > 0 && rx_done_q[0] == cyc,
                      o_rx_config_done);
            if (tx_done_q.size() > 0 && tx_done_q[0] == cyc)
                tx_done_q.delete(0);
            if (rx_done_q.size() > 0 && rx_done_q[0] == cyc)
                rx_done_q.delete(0);
        end
    end

    initial begin
        logic [REG_W-1:0] w, tx_addr_w;
        int               cnt;
        clk = 1'b0;
        rst = 1'b1;
        {i_reg_wen, i_reg_ren, i_reg_waddr, i_reg_raddr, i_reg_wdata} = '0;
        {i_tx_interrupt, i_rx_interrupt, i_loss_interrupt, i_sync_loss, i_link_loss} = '0;
        {i_rx_status, i_tx_status, i_rx_frame_length} = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst      = 1'b0;
        checking = 1'b1;

        // settings registers
        for (int r = 0; r < 3; r++) begin
            w = random_bits(64);
            write_reg(TX_ADDR_REG, w);
            check_field("tx base address", slice_field(w, 0, 32), o_tx_base_addr);
            read_expect(TX_ADDR_REG, w, "tx address read-back");
            tx_addr_w = w;
            w = random_bits(64);
            write_reg(TX_LENGTH_REG, w);
            check_field("tx total length", slice_field(w, 0, 32), o_tx_total_length);
            read_expect(TX_LENGTH_REG, w, "tx length read-back");
            w = random_bits(64);
            write_reg(TX_PACKET_REG, w);
            check_field("tx packet body", slice_field(w, 0, 16), 32'(o_tx_packet_body));
            check_field("tx body count", slice_field(w, 16, 24), 32'(o_tx_body_num));
            check_field("tx packet tail", slice_field(w, 40, 16), 32'(o_tx_packet_tail));
            check_bit("tx pre-emphasis", w[59], o_tx_pre);
            check_field("tx mode", slice_field(w, 60, 3), 32'(o_tx_mode));
            check_bit("loopback enable", w[63], o_loopback_ena);
            read_expect(TX_PACKET_REG, w, "tx packet read-back");
            w = random_bits(64);
            write_reg(RX_ADDR_REG, w);
            check_field("rx base address", slice_field(w, 0, 32), o_rx_base_addr);
            read_expect(RX_ADDR_REG, w, "rx address read-back");
            // auto start kept low until the pulse train test
            w = random_bits(64) & ~(64'd1 << 3);
            write_reg(RX_CTRL_REG, w);
            check_bit("rx fifo read", w[0], o_rx_fifo_rd);
            check_bit("link loss enable", w[1], o_link_loss_detect_ena);
            check_bit("sync loss enable", w[2], o_sync_loss_detect_ena);
            read_expect(RX_CTRL_REG, w, "rx control read-back");
            w = random_bits(64);
            write_reg(RX_CTRL_REG2, w);
            check_field("rx line count", slice_field(w, 0, 24), 32'(o_line_num_per_intr));
            read_expect(RX_CTRL_REG2, '0, "write-only rx control 2");
        end

        // config-done strobes, window misses, status words
        write_reg(TX_CFG_REG, random_bits(64));
        write_reg(RX_CFG_REG, random_bits(64));
        write_reg(16'h0108, random_bits(64));
        write_reg(16'h0120, random_bits(64));
        read_expect(TX_ADDR_REG, tx_addr_w, "tx address after stray write");
        read_expect(16'h0120, '0, "read outside window");
        read_expect(16'h0018, '0, "unused offset");
        i_tx_status = TX_STATUS_W'(random_bits(TX_STATUS_W));
        i_rx_status = RX_STATUS_W'(random_bits(RX_STATUS_W));
        read_expect(TX_STATUS_REG, status_word(TX_STATUS_TAG, 32'(i_tx_status), 0, 16'h0),
                    "tx status read");
        read_expect(RX_STATUS_REG, status_word(RX_STATUS_TAG, 32'(i_rx_status), 0, 16'h0),
                    "rx status read");

        ///////////////////////////////////////////////////////////////////
        // interrupt edges and soft reset
        ///////////////////////////////////////////////////////////////////
        for (int n = 1; n <= 2; n++) begin
            pulse_interrupt(0);
            read_expect(IRQ_REG, status_word(IRQ_CODE_TX, n, 16, TX_IRQ_MARK), "tx irq status");
        end
        i_rx_frame_length = RX_FLEN_W'(random_bits(RX_FLEN_W));
        for (int n = 1; n <= 2; n++) begin
            pulse_interrupt(1);
            read_expect(IRQ_REG, status_word(IRQ_CODE_RX, (n << 16) | i_rx_frame_length, 32,
                        16'h0), "rx irq status");
        end
        i_sync_loss = 1'b1;
        pulse_interrupt(2);
        read_expect(IRQ_REG, status_word(IRQ_CODE_LOSS, {i_rx_status, i_sync_loss, i_link_loss},
                    0, 16'h0), "loss irq status");
        write_reg(SOFT_R_REG, '0);
        cnt = 0;
        while (o_soft_rst) begin
            cnt++;
            if (cnt > 2 * SOFT_RST_CYCLES)
                timeout_fail("soft reset release");
            @(negedge clk);
        end
        check_field("soft reset length", SOFT_RST_CYCLES, cnt);
        pulse_interrupt(0);
        read_expect(IRQ_REG, status_word(IRQ_CODE_TX, 1, 16, TX_IRQ_MARK), "tx count after reset");

        // auto train of three pulses of width two after a gap of four
        w = (64'd1 << 3) | (64'd3 << 4) | (64'd4 << 12) | (64'd2 << 40);
        write_reg(RX_CTRL_REG, w);
        for (int p = 0; p < 3; p++) begin
            cnt = 0;
            while (!o_rx_irq) begin
                cnt++;
                if (cnt > 64)
                    timeout_fail("an auto interrupt pulse");
                @(negedge clk);
            end
            cnt = 0;
            while (o_rx_irq) begin
                cnt++;
                if (cnt > 64)
                    timeout_fail("the end of an auto interrupt pulse");
                @(negedge clk);
            end
            check_field("auto pulse width", 2, cnt);
        end
        repeat (16) begin
            check_bit("rx irq after the train", 1'b0, o_rx_irq);
            @(negedge clk);
        end
        // count equals the programmed number of pulses
        read_expect(IRQ_REG, status_word(IRQ_CODE_AUTO, 3, 16, AUTO_IRQ_MARK), "auto irq status");

        @(negedge clk);
        if (rd_due_q.size() + tx_done_q.size() + rx_done_q.size() != 0) begin
            $display("some expected responses were never checked");
            stop_with_failure();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

/* flist.f */
+incdir+tests
hdl/reg_pkg.sv
hdl/reg_bus_stage.sv
hdl/cfg_regs.sv
hdl/auto_intr_gen.sv
hdl/intr_report.sv
hdl/reg_mgt_top.sv
tests/tb_reg_mgt.sv

/* run_sim.sh */
#!/bin/sh
# build and run the register manager testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_reg_mgt \
    -o sim_reg_mgt
./obj_dir/sim_reg_mgt > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "run_sim: failure reported"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "run_sim: simulation ended without a result"
    exit 1
fi
echo "run_sim: done"
